//--- filelist.f
rtl/Sm83Pkg.sv
rtl/AluBitSlice.sv
rtl/Decoder.sv
rtl/Sequencer.sv
rtl/Accumulator.sv
rtl/Sm83Core.sv
testbench/Sm83CoreTb.sv

//--- Bender.yml
package:
  name: sm83_core

sources:
  - rtl/Sm83Pkg.sv
  - rtl/AluBitSlice.sv
  - rtl/Decoder.sv
  - rtl/Sequencer.sv
  - rtl/Accumulator.sv
  - rtl/Sm83Core.sv
  - target: test
    files:
      - testbench/Sm83CoreTb.sv

//--- testbench/Sm83CoreTb.sv
`default_nettype none

module Sm83CoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] ResetVector = 16'h0100;
	localparam int RandOps = 12;
	// Each instruction takes at most four machine cycles
	localparam int TotalInstrs = 2 + 3 + 2 * (2 * RandOps + 2) + (1 + 9 * 3 + 1) + 6;
	localparam int WatchdogClocks = TotalInstrs * 8 + 100;

	logic        CLK;
	logic        reset;
	logic [15:0] addr;
	logic        rd;
	logic        wr;
	logic [7:0]  dataIn;
	logic [7:0]  dataOut;

	logic [7:0]  mem [0:65535];
	logic [15:0] readLog [$];
	logic [15:0] writeAddr [$];
	logic [7:0]  writeData [$];
	logic [15:0] endAddr;
	logic [15:0] progPtr;
	logic        seenEnd;
	logic        prevRd;
	logic        prevWr;
	logic [15:0] prevAddr;
	int          wrClocks;
	int          rdAtVector;
	logic [31:0] rngState;
	logic [7:0]  modelA;
	logic [3:0]  modelF;   // Z N H C

	Sm83Core #(
		.ResetVector(ResetVector)
	) DUT (
		.CLK(CLK),
		.reset(reset),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.dataIn(dataIn),
		.dataOut(dataOut) );

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Memory answers every read clock
	always @(posedge CLK) begin
		if (rd)
			dataIn <= mem[addr];
	end

	// One read entry per machine cycle
	always @(posedge CLK) begin
		if (reset) begin
			prevRd = 1'b0;
			prevWr = 1'b0;
		end else begin
			if (rd && (!prevRd || addr != prevAddr)) begin
				readLog.push_back(addr);
				if (addr == endAddr)
					seenEnd = 1'b1;
			end
			if (wr && !prevWr) begin
				writeAddr.push_back(addr);
				writeData.push_back(dataOut);
			end
			if (wr)
				wrClocks++;
			if (rd && addr == ResetVector)
				rdAtVector++;
			prevRd = rd;
			prevWr = wr;
			prevAddr = addr;
		end
	end

	initial begin
		repeat (WatchdogClocks) @(posedge CLK);
		$display("Timeout: the tests did not finish within %0d clocks", WatchdogClocks);
		$display("Simulation failed");
		$fatal(1);
	end

	function automatic logic [7:0] randByte();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState[7:0];
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("Mismatch at %0t ns: %s", $time, msg);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic emit(input logic [7:0] b);
		mem[progPtr] = b;
		progPtr = progPtr + 16'd1;
	endtask

	// Program ends in a jump onto itself
	task automatic emitEnd();
		endAddr = progPtr;
		emit(8'hC3);
		emit(endAddr[7:0]);
		emit(endAddr[15:8]);
	endtask

	task automatic startProgram();
		progPtr = ResetVector;
		modelA = 8'h00;
		modelF = 4'h0;
	endtask

	task automatic runProgram();
		reset <= 1'b1;
		repeat (2) @(posedge CLK);
		reset <= 1'b0;
		readLog.delete();
		writeAddr.delete();
		writeData.delete();
		seenEnd = 1'b0;
		wrClocks = 0;
		rdAtVector = 0;
		while (!seenEnd)
			@(posedge CLK);
	endtask

	// Expected A and F for one immediate ALU instruction
	task automatic aluModel(input logic [7:0] op, input logic [7:0] b);
		int cin;
		int res;
		logic h;
		logic c;
		cin = modelF[0];
		h = 1'b0;
		c = 1'b0;
		case (op)
			8'hC6, 8'hCE: begin
				if (op == 8'hC6)
					cin = 0;
				res = modelA + b + cin;
				h = (modelA[3:0] + b[3:0] + cin) > 15;
				c = res > 255;
			end
			8'hD6, 8'hDE, 8'hFE: begin
				if (op != 8'hDE)
					cin = 0;
				res = modelA - b - cin;
				h = int'(modelA[3:0]) < int'(b[3:0]) + cin;
				c = int'(modelA) < int'(b) + cin;
			end
			8'hE6: begin
				res = modelA & b;
				h = 1'b1;
			end
			8'hEE: res = modelA ^ b;
			default: res = modelA | b;
		endcase
		modelF = {res[7:0] == 8'h00, op inside {8'hD6, 8'hDE, 8'hFE}, h, c};
		if (op != 8'hFE)
			modelA = res[7:0];
	endtask

	task automatic firstFetchTest();
		startProgram();
		emit(8'h00);
		emitEnd();
		runProgram();
		check(readLog[0] == ResetVector, "first fetch not at the reset vector");
		check(rdAtVector == 2, $sformatf("rd high %0d clocks at vector", rdAtVector));
		check(wrClocks == 0, "wr high during the first fetch");
	endtask

	task automatic storeTest();
		startProgram();
		emit(8'h3E);
		emit(8'h5A);
		emit(8'hE0);
		emit(8'h42);
		emitEnd();
		runProgram();
		check(writeAddr.size() == 1, "LDH did not write exactly once");
		check(writeAddr[0] == 16'hFF42, $sformatf("store address %h", writeAddr[0]));
		check(writeData[0] == 8'h5A, $sformatf("store data %h", writeData[0]));
		check(wrClocks == 2, $sformatf("wr high %0d clocks", wrClocks));
	endtask

	task automatic randomAluTest(input logic logicOps);
		logic [7:0] expA [$];
		logic [7:0] op;
		logic [7:0] b;
		logic [7:0] logicOpcodes [3] = '{8'hE6, 8'hEE, 8'hF6};
		logic [7:0] arithOpcodes [5] = '{8'hC6, 8'hCE, 8'hD6, 8'hDE, 8'hFE};
		startProgram();
		b = randByte();
		emit(8'h3E);
		emit(b);
		modelA = b;
		for (int k = 0; k < RandOps; k++) begin
			if (logicOps)
				op = logicOpcodes[randByte() % 3];
			else
				op = arithOpcodes[randByte() % 5];
			b = randByte();
			emit(op);
			emit(b);
			aluModel(op, b);
			emit(8'hE0);
			emit(k[7:0]);
			expA.push_back(modelA);
		end
		emitEnd();
		runProgram();
		check(writeData.size() == RandOps, "wrong number of stores");
		for (int k = 0; k < RandOps; k++) begin
			check(writeAddr[k] == {8'hFF, k[7:0]}, $sformatf("store %0d address", k));
			check(writeData[k] == expA[k],
				$sformatf("op %0d stored %h, expected %h", k, writeData[k], expA[k]));
		end
	endtask

	task automatic jumpTest();
		logic [7:0]  jpOps [9] = '{8'hCA, 8'hC2, 8'hDA, 8'hD2, 8'hCA, 8'hC2, 8'hDA, 8'hD2, 8'hC3};
		logic [15:0] jpAt [9];
		logic [15:0] expNext [9];
		logic [15:0] target;
		logic        taken;
		int          idx;
		startProgram();
		emit(8'h3E);
		emit(8'h05);
		modelA = 8'h05;
		for (int i = 0; i < 9; i++) begin
			emit(8'hFE);
			emit(i < 4 ? 8'h05 : 8'h06);   // Z=1 C=0, then Z=0 C=1
			aluModel(8'hFE, i < 4 ? 8'h05 : 8'h06);
			jpAt[i] = progPtr;
			target = progPtr + 16'd6;
			case (jpOps[i])
				8'hCA: taken = modelF[3];
				8'hC2: taken = !modelF[3];
				8'hDA: taken = modelF[0];
				8'hD2: taken = !modelF[0];
				default: taken = 1'b1;
			endcase
			expNext[i] = taken ? target : jpAt[i] + 16'd3;
			emit(jpOps[i]);
			emit(target[7:0]);
			emit(target[15:8]);
			emit(8'hC3);
			emit(target[7:0]);
			emit(target[15:8]);
		end
		emitEnd();
		runProgram();
		for (int i = 0; i < 9; i++) begin
			idx = -1;
			foreach (readLog[j])
				if (idx < 0 && readLog[j] == jpAt[i])
					idx = j;
			check(idx >= 0, $sformatf("jump %0d never fetched", i));
			check(readLog[idx + 3] == expNext[i],
				$sformatf("jump %h fetched next %h, expected %h",
				jpOps[i], readLog[idx + 3], expNext[i]));
		end
	endtask

	task automatic nopTest();
		startProgram();
		emit(8'h3E);
		emit(8'hA7);
		emit(8'h00);
		emit(8'h76);
		emit(8'h47);
		emit(8'hE0);
		emit(8'h20);
		emitEnd();
		runProgram();
		for (int k = 2; k < 6; k++)
			check(readLog[k] == ResetVector + k, $sformatf("fetch %0d at %h", k, readLog[k]));
		check(writeData.size() == 1, "no store after NOPs");
		check(writeData[0] == 8'hA7, $sformatf("A changed to %h", writeData[0]));
	endtask

	initial begin
		reset = 1'b1;
		dataIn = 8'h00;
		rngState = 32'h1eee_0128;
		endAddr = 16'hFFFF;
		seenEnd = 1'b0;
		prevAddr = 16'h0000;
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h3C;
		firstFetchTest();
		storeTest();
		randomAluTest(1'b0);
		randomAluTest(1'b1);
		jumpTest();
		nopTest();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/Sm83Core.sv
`default_nettype none

module Sm83Core #(
	parameter logic [15:0] ResetVector = 16'h0000
) (
	input  logic        CLK,
	input  logic        reset,
	output logic [15:0] addr,
	output logic        rd,
	output logic        wr,
	input  logic [7:0]  dataIn,
	output logic [7:0]  dataOut
);

	Sm83Pkg::InstrInfo info;
	Sm83Pkg::Opcode    opcode;
	Sm83Pkg::SliceCtrl sliceCtrl;
	Sm83Pkg::Flags     flags;

	logic [7:0] operand;
	logic [7:0] accA;
	logic [7:0] aBits;
	logic [7:0] bBits;
	logic [7:0] sliceResult;
	logic [8:0] carry;     // Ripple chain, carry[0] from decoder
	logic       execute;

	Sequencer #(
		.ResetVector(ResetVector)
	) seq (
		.CLK(CLK),
		.reset(reset),
		.dataIn(dataIn),
		.accA(accA),
		.flags(flags),
		.info(info),
		.opcode(opcode),
		.operand(operand),
		.execute(execute),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.dataOut(dataOut) );

	Decoder dec (
		.opcode(opcode),
		.operand(operand),
		.accA(accA),
		.carryFlag(flags.carry),
		.info(info),
		.sliceCtrl(sliceCtrl),
		.aBits(aBits),
		.bBits(bBits),
		.carryIn(carry[0]) );

	for (genvar i = 0; i < 8; i++) begin : gSlice
		AluBitSlice slice (
			.ctrl(sliceCtrl),
			.a(aBits[i]),
			.b(bBits[i]),
			.carryIn(carry[i]),
			.result(sliceResult[i]),
			.carryOut(carry[i+1]) );
	end

	Accumulator acc (
		.CLK(CLK),
		.reset(reset),
		.execute(execute),
		.info(info),
		.sliceResult(sliceResult),
		.halfCarryOut(carry[4]),   // Out of bit 3
		.carryOut(carry[8]),
		.accA(accA),
		.flags(flags) );

endmodule

`default_nettype wire

//--- rtl/Accumulator.sv
`default_nettype none

module Accumulator (
	input  logic              CLK,
	input  logic              reset,
	input  logic              execute,
	input  Sm83Pkg::InstrInfo info,
	input  logic [7:0]        sliceResult,
	input  logic              halfCarryOut,
	input  logic              carryOut,
	output logic [7:0]        accA,
	output Sm83Pkg::Flags     flags
);

	Sm83Pkg::Flags newFlags;

	always_comb begin
		newFlags = flags;
		newFlags.zero = sliceResult == 8'h00;   // CP too, though A is kept
		case (info.aluOp)
			Sm83Pkg::AluAdd,
			Sm83Pkg::AluAdc: begin
				newFlags.subtract = 1'b0;
				newFlags.halfCarry = halfCarryOut;
				newFlags.carry = carryOut;
			end
			Sm83Pkg::AluSub,
			Sm83Pkg::AluSbc,
			Sm83Pkg::AluCp: begin
				newFlags.subtract = 1'b1;
				newFlags.halfCarry = !halfCarryOut;   // Borrow
				newFlags.carry = !carryOut;
			end
			Sm83Pkg::AluAnd: begin
				newFlags.subtract = 1'b0;
				newFlags.halfCarry = 1'b1;
				newFlags.carry = 1'b0;
			end
			Sm83Pkg::AluXor,
			Sm83Pkg::AluOr: begin
				newFlags.subtract = 1'b0;
				newFlags.halfCarry = 1'b0;
				newFlags.carry = 1'b0;
			end
			default: newFlags = flags;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			accA <= 8'h00;
			flags <= '0;
		end else if (execute) begin
			if (info.writeA)
				accA <= sliceResult;
			if (info.writeFlags)
				flags <= newFlags;
		end
	end

	// Sequencer only pulses for instructions with a result
	assert property (@(posedge CLK) disable iff (reset)
		execute |-> (info.writeA || info.writeFlags));

endmodule

`default_nettype wire

//--- rtl/Sequencer.sv
`default_nettype none

module Sequencer #(
	parameter logic [15:0] ResetVector = 16'h0000
) (
	input  logic              CLK,
	input  logic              reset,
	input  logic [7:0]        dataIn,
	input  logic [7:0]        accA,
	input  Sm83Pkg::Flags     flags,
	input  Sm83Pkg::InstrInfo info,
	output Sm83Pkg::Opcode    opcode,
	output logic [7:0]        operand,
	output logic              execute,
	output logic [15:0]       addr,
	output logic              rd,
	output logic              wr,
	output logic [7:0]        dataOut
);

	Sm83Pkg::MState mState;
	Sm83Pkg::MState nextState;
	Sm83Pkg::Opcode opcodeReg;

	logic        phaseT2;
	logic [15:0] pc;         // Address of the byte read in this cycle
	logic [15:0] pcInc;
	logic [15:0] nextPc;
	logic [15:0] nextAddr;
	logic [7:0]  operandLo;
	logic        nextRd;
	logic        nextWr;
	logic        condMet;
	logic        startExec;

	assign pcInc = pc + 16'd1;
	assign operand = operandLo;

	// Decoder sees the incoming byte during fetch T2
	assign opcode = (mState == Sm83Pkg::StFetch && phaseT2) ?
		Sm83Pkg::Opcode'(dataIn) : opcodeReg;

	always_comb begin
		case (info.cond)
			Sm83Pkg::CondAlways: condMet = 1'b1;
			Sm83Pkg::CondNz:     condMet = !flags.zero;
			Sm83Pkg::CondZ:      condMet = flags.zero;
			Sm83Pkg::CondNc:     condMet = !flags.carry;
			Sm83Pkg::CondC:      condMet = flags.carry;
			default:             condMet = 1'b0;
		endcase
	end

	// Next machine cycle, chosen at the end of T2
	always_comb begin
		nextState = Sm83Pkg::StFetch;
		nextPc = pcInc;
		nextAddr = pcInc;
		startExec = 1'b0;
		case (mState)
			Sm83Pkg::StFetch: begin
				if (info.immBytes != 2'd0)
					nextState = Sm83Pkg::StImmLo;
			end
			Sm83Pkg::StImmLo: begin
				if (info.isJump) begin
					nextState = Sm83Pkg::StImmHi;
				end else if (info.isStore) begin
					nextState = Sm83Pkg::StWrite;
					nextPc = pc;
					nextAddr = {8'hFF, dataIn};   // High page
				end else begin
					startExec = info.writeA || info.writeFlags;
				end
			end
			Sm83Pkg::StImmHi: begin
				if (condMet) begin
					nextState = Sm83Pkg::StIdle;
					nextPc = {dataIn, operandLo};
					nextAddr = {dataIn, operandLo};
				end
			end
			Sm83Pkg::StIdle: begin
				nextPc = pc;
				nextAddr = pc;
			end
			default: ;   // StWrite resumes at pc+1
		endcase
		nextRd = nextState inside {Sm83Pkg::StFetch, Sm83Pkg::StImmLo, Sm83Pkg::StImmHi};
		nextWr = nextState == Sm83Pkg::StWrite;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			mState <= Sm83Pkg::StIdle;   // Leaves into the first fetch
			phaseT2 <= 1'b1;
			pc <= ResetVector;
			addr <= ResetVector;
			rd <= 1'b0;
			wr <= 1'b0;
			execute <= 1'b0;
			opcodeReg <= Sm83Pkg::OpNop;
		end else if (!phaseT2) begin
			phaseT2 <= 1'b1;
			execute <= 1'b0;
		end else begin
			phaseT2 <= 1'b0;
			mState <= nextState;
			pc <= nextPc;
			addr <= nextAddr;
			rd <= nextRd;
			wr <= nextWr;
			execute <= startExec;
			if (mState == Sm83Pkg::StFetch)
				opcodeReg <= opcode;
		end
	end

	always_ff @(posedge CLK) begin
		if (phaseT2 && mState == Sm83Pkg::StImmLo)
			operandLo <= dataIn;
		if (phaseT2 && nextState == Sm83Pkg::StWrite)
			dataOut <= accA;
	end

	assert property (@(posedge CLK) disable iff (reset) !(rd && wr));

	// Bus held from T1 into T2
	assert property (@(posedge CLK) disable iff (reset) phaseT2 |-> $stable(addr));

endmodule

`default_nettype wire

//--- rtl/Decoder.sv
`default_nettype none

module Decoder (
	input  Sm83Pkg::Opcode    opcode,
	input  logic [7:0]        operand,
	input  logic [7:0]        accA,
	input  logic              carryFlag,
	output Sm83Pkg::InstrInfo info,
	output Sm83Pkg::SliceCtrl sliceCtrl,
	output logic [7:0]        aBits,
	output logic [7:0]        bBits,
	output logic              carryIn
);

	always_comb begin
		info = '0;
		info.aluOp = Sm83Pkg::AluPass;
		info.cond = Sm83Pkg::CondAlways;
		case (opcode)
			Sm83Pkg::OpLdAImm: begin
				info.writeA = 1'b1;
				info.immBytes = 2'd1;
			end
			Sm83Pkg::OpAddImm:   info.aluOp = Sm83Pkg::AluAdd;
			Sm83Pkg::OpAdcImm:   info.aluOp = Sm83Pkg::AluAdc;
			Sm83Pkg::OpSubImm:   info.aluOp = Sm83Pkg::AluSub;
			Sm83Pkg::OpSbcImm:   info.aluOp = Sm83Pkg::AluSbc;
			Sm83Pkg::OpAndImm:   info.aluOp = Sm83Pkg::AluAnd;
			Sm83Pkg::OpXorImm:   info.aluOp = Sm83Pkg::AluXor;
			Sm83Pkg::OpOrImm:    info.aluOp = Sm83Pkg::AluOr;
			Sm83Pkg::OpCpImm:    info.aluOp = Sm83Pkg::AluCp;
			Sm83Pkg::OpLdhStore: begin
				info.immBytes = 2'd1;
				info.isStore = 1'b1;
			end
			Sm83Pkg::OpJp:       info.isJump = 1'b1;
			Sm83Pkg::OpJpZ: begin
				info.isJump = 1'b1;
				info.cond = Sm83Pkg::CondZ;
			end
			Sm83Pkg::OpJpNz: begin
				info.isJump = 1'b1;
				info.cond = Sm83Pkg::CondNz;
			end
			Sm83Pkg::OpJpC: begin
				info.isJump = 1'b1;
				info.cond = Sm83Pkg::CondC;
			end
			Sm83Pkg::OpJpNc: begin
				info.isJump = 1'b1;
				info.cond = Sm83Pkg::CondNc;
			end
			default: ;   // NOP and unknown opcodes
		endcase
		// ALU immediates share the rest of their control
		if (info.aluOp != Sm83Pkg::AluPass) begin
			info.writeA = info.aluOp != Sm83Pkg::AluCp;
			info.writeFlags = 1'b1;
			info.immBytes = 2'd1;
		end
		if (info.isJump)
			info.immBytes = 2'd2;
	end

	always_comb begin
		sliceCtrl.op = info.aluOp;
		sliceCtrl.invertB = info.aluOp inside {Sm83Pkg::AluSub, Sm83Pkg::AluSbc, Sm83Pkg::AluCp};
		aBits = accA;
		bBits = sliceCtrl.invertB ? ~operand : operand;   // Two's complement subtract
		case (info.aluOp)
			Sm83Pkg::AluAdc: carryIn = carryFlag;
			Sm83Pkg::AluSbc: carryIn = !carryFlag;
			Sm83Pkg::AluSub,
			Sm83Pkg::AluCp:  carryIn = 1'b1;
			default:         carryIn = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/AluBitSlice.sv
`default_nettype none

module AluBitSlice (
	input  Sm83Pkg::SliceCtrl ctrl,
	input  logic              a,
	input  logic              b,
	input  logic              carryIn,
	output logic              result,
	output logic              carryOut
);

	logic sum;
	logic ripple;
	logic bTrue;

	assign sum = a ^ b ^ carryIn;
	assign ripple = (a & b) | (carryIn & (a ^ b));
	assign bTrue = b ^ ctrl.invertB;   // Operand before subtract inversion

	always_comb begin
		result = 1'b0;
		carryOut = 1'b0;
		case (ctrl.op)
			Sm83Pkg::AluAdd,
			Sm83Pkg::AluAdc,
			Sm83Pkg::AluSub,
			Sm83Pkg::AluSbc,
			Sm83Pkg::AluCp: begin
				result = sum;
				carryOut = ripple;
			end
			Sm83Pkg::AluAnd:  result = a & bTrue;
			Sm83Pkg::AluXor:  result = a ^ bTrue;
			Sm83Pkg::AluOr:   result = a | bTrue;
			Sm83Pkg::AluPass: result = bTrue;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/Sm83Pkg.sv
`default_nettype none

package Sm83Pkg;

	// Supported SM83 opcodes
	typedef enum logic [7:0] {
		OpNop      = 8'h00,
		OpLdAImm   = 8'h3E,
		OpJpNz     = 8'hC2,
		OpJp       = 8'hC3,
		OpAddImm   = 8'hC6,
		OpJpZ      = 8'hCA,
		OpAdcImm   = 8'hCE,
		OpJpNc     = 8'hD2,
		OpSubImm   = 8'hD6,
		OpJpC      = 8'hDA,
		OpSbcImm   = 8'hDE,
		OpLdhStore = 8'hE0,   // LDH (a8),A
		OpAndImm   = 8'hE6,
		OpXorImm   = 8'hEE,
		OpOrImm    = 8'hF6,
		OpCpImm    = 8'hFE
	} Opcode;

	typedef enum logic [3:0] {
		AluPass,
		AluAdd,
		AluAdc,
		AluSub,
		AluSbc,
		AluAnd,
		AluXor,
		AluOr,
		AluCp
	} AluOp;

	typedef enum logic [2:0] {
		StFetch,
		StImmLo,
		StImmHi,
		StWrite,
		StIdle
	} MState;

	typedef enum logic [2:0] {
		CondAlways,
		CondNz,
		CondZ,
		CondNc,
		CondC
	} Condition;

	// Upper nibble of F, bit order as on the chip
	typedef struct packed {
		logic zero;
		logic subtract;
		logic halfCarry;
		logic carry;
	} Flags;

	typedef struct packed {
		AluOp     aluOp;
		logic     writeA;
		logic     writeFlags;
		logic [1:0] immBytes;   // Operand bytes after the opcode
		logic     isStore;
		logic     isJump;
		Condition cond;
	} InstrInfo;

	typedef struct packed {
		AluOp op;
		logic invertB;
	} SliceCtrl;

endpackage

`default_nettype wire
